//--- Makefile
TOP  := tb_pwm_subsystem
SRCS := $(filter-out +incdir+%,$(shell cat all.f)) src/pwm_config.svh

.PHONY: all run clean

all: run

# the binary is rebuilt only when a source or the file list changes.
obj_dir/V$(TOP): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+src
src/pwm_pkg.sv
src/apb_register_if.sv
src/pwm_prescaler.sv
src/pwm_channel.sv
src/pwm_subsystem_top.sv
sim/tb_pwm_subsystem.sv

//--- sim/tb_pwm_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pwm_subsystem
    import pwm_pkg::*;
();

    localparam int CLK_PERIOD     = 20;
    localparam int APB_XFERS      = 60;  // transfers over all tests, three cycles each.
    localparam int PWM_PERIODS    = 24;
    localparam int MAX_PERIOD_CLK = 32;  // longest (P+1)*(d+1) used below.
    localparam int TIMEOUT_CYCLES = 2 * (APB_XFERS * 3 + PWM_PERIODS * MAX_PERIOD_CLK);

    logic       clk;
    logic       resetn;
    logic       apb_psel;
    logic       apb_enab;
    logic       apb_rw;
    apb_addr_t  apb_addr;
    apb_word_t  apb_datai;
    apb_word_t  apb_datao;
    logic       apb_ack;
    logic [1:0] pwm_out;

    int seed = 51327;

    pwm_subsystem_top pwm_subsystem_top_i (
        .clk       (clk),
        .resetn    (resetn),
        .apb_psel  (apb_psel),
        .apb_enab  (apb_enab),
        .apb_rw    (apb_rw),
        .apb_addr  (apb_addr),
        .apb_datai (apb_datai),
        .apb_datao (apb_datao),
        .apb_ack   (apb_ack),
        .pwm_out   (pwm_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            else stop_run($sformatf("[FAIL] %s: expected 0x%08h, actual 0x%08h",
                                    name, expected, actual));
    endtask

    // ack must be high in the access cycle and nowhere else.
    ack_in_access: assert property (@(posedge clk) disable iff (!resetn)
        (apb_psel && apb_enab) |-> apb_ack)
        else stop_run("apb_ack was low during an access cycle");

    ack_only_in_access: assert property (@(posedge clk) disable iff (!resetn)
        !(apb_psel && apb_enab) |-> !apb_ack)
        else stop_run("apb_ack was high in a setup or idle cycle");

    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_word_t wdata, output apb_word_t rdata);
        @(negedge clk);
        apb_psel  = 1'b1;   // setup cycle.
        apb_enab  = 1'b0;
        apb_rw    = write;
        apb_addr  = addr;
        apb_datai = wdata;
        @(negedge clk);
        apb_enab = 1'b1;
        assert (apb_ack === 1'b1)
            else stop_run("the APB ack did not arrive in the access cycle");
        rdata = apb_datao;
        @(negedge clk);
        apb_psel = 1'b0;
        apb_enab = 1'b0;
        apb_rw   = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_word_t data);
        apb_word_t unused;
        apb_transfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_word_t data);
        apb_transfer(1'b0, addr, '0, data);
    endtask

    task automatic write_reg(input reg_index_e idx, input apb_word_t data);
        apb_write(apb_addr_t'(idx), data);
    endtask

    // skips the partial first period and stops where a full one begins.
    task automatic sync_to_period(input int ch);
        while (pwm_out[ch] !== 1'b1) @(negedge clk);
        while (pwm_out[ch] === 1'b1) @(negedge clk);
        while (pwm_out[ch] !== 1'b1) @(negedge clk);
    endtask

    task automatic run_length(input int ch, input logic level, output int len);
        len = 0;
        while (pwm_out[ch] === level) begin
            len++;
            @(negedge clk);
        end
    endtask

    task automatic check_period(input int ch, input int exp_high, input int exp_low,
                                input string name);
        int high_len;
        int low_len;
        run_length(ch, 1'b1, high_len);
        run_length(ch, 1'b0, low_len);
        check_value({name, " high run"}, exp_high, high_len);
        check_value({name, " low run"}, exp_low, low_len);
    endtask

    task automatic hold_check(input int ch, input logic level, input int skip,
                              input int cycles, input string name);
        repeat (skip) @(negedge clk);
        repeat (cycles) begin
            check_value(name, {31'b0, level}, {31'b0, pwm_out[ch]});
            @(negedge clk);
        end
    endtask

    initial begin
        apb_word_t rdata;
        apb_word_t wdata [8];
        int        div;
        int        per;
        int        dut;
        int        per_clk;

        resetn    = 1'b0;
        apb_psel  = 1'b0;
        apb_enab  = 1'b0;
        apb_rw    = 1'b0;
        apb_addr  = '0;
        apb_datai = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        for (int i = 0; i < 8; i++) begin
            apb_read(apb_addr_t'(i), rdata);
            check_value($sformatf("reset R%0d", i), 32'h0, rdata);
        end
        check_value("reset pwm_out", 32'h0, {30'b0, pwm_out});

        // odd registers are written through their alias at 8+k.
        for (int i = 0; i < 8; i++) begin
            wdata[i] = $random(seed);
            apb_write(apb_addr_t'((i % 2 == 1) ? i + 8 : i), wdata[i]);
        end
        for (int i = 0; i < 8; i++) begin
            apb_read(apb_addr_t'(i), rdata);
            check_value($sformatf("readback R%0d", i), wdata[i], rdata);
        end
        write_reg(REG_CTRL, 32'h0);  // stopped channels let the shadows follow.

        // channel 0 with divisor 2, period 9, duty 4.
        write_reg(REG_CH0_PERIOD, 32'd9);
        write_reg(REG_CH0_DUTY, 32'd4);
        write_reg(REG_CTRL, (2 << 8) | 1);
        sync_to_period(0);
        repeat (3) check_period(0, 4 * 3, (10 - 4) * 3, "ch0 duty");

        // a duty write inside a period only shows in the next one.
        fork
            check_period(0, 4 * 3, (10 - 4) * 3, "ch0 period during duty update");
            begin
                repeat (4) @(negedge clk);
                write_reg(REG_CH0_DUTY, 32'd7);
            end
        join
        check_period(0, 7 * 3, (10 - 7) * 3, "ch0 period after duty update");

        div     = $random(seed) & 3;
        per     = 2 + (($random(seed) & 7) % 6);
        dut     = 1 + (($random(seed) & 15) % per);
        per_clk = (per + 1) * (div + 1);
        write_reg(REG_CH1_PERIOD, per);
        write_reg(REG_CH1_DUTY, dut);
        write_reg(REG_CTRL, (div << 8) | 2);
        hold_check(0, 1'b0, 2, 4, "ch0 disabled");
        sync_to_period(1);
        repeat (3) begin
            check_period(1, dut * (div + 1), (per + 1 - dut) * (div + 1), "ch1 duty");
        end

        write_reg(REG_CH1_DUTY, 32'h0);
        hold_check(1, 1'b0, per_clk + 2, 2 * per_clk, "ch1 duty zero");
        write_reg(REG_CH1_DUTY, per + 1);
        hold_check(1, 1'b1, per_clk + 2, 2 * per_clk, "ch1 duty above period");

        write_reg(REG_CTRL, 32'h0);
        hold_check(1, 1'b0, 2, 4, "ch1 disabled");

        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        stop_run("the watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

//--- src/apb_register_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwm_config.svh"

module apb_register_if
    import pwm_pkg::*;
#(
    parameter int REG_NUM = `REG_NUM
) (
    input  wire logic      clk,
    input  wire logic      resetn,

    input  wire logic      apb_psel,
    input  wire logic      apb_enab,
    input  wire logic      apb_rw,     // 1 for write, 0 for read.
    input  wire apb_addr_t apb_addr,
    input  wire apb_word_t apb_datai,
    output apb_word_t      apb_datao,
    output logic           apb_ack,

    output apb_word_t      R0,
    output apb_word_t      R1,
    output apb_word_t      R2,
    output apb_word_t      R3,
    output apb_word_t      R4,
    output apb_word_t      R5,
    output apb_word_t      R6,
    output apb_word_t      R7
);

    localparam int REG_ADDR_W = $clog2(REG_NUM);
    localparam int MAX_REGS   = 8;

    typedef enum logic {
        IDLE,
        ACCESS
    } apb_state_e;

    apb_state_e             state;
    apb_word_t              regs [MAX_REGS];
    logic [REG_ADDR_W-1:0]  reg_idx;
    logic                   setup_phase;
    logic                   write_commit;

    if (REG_NUM < 2 || REG_NUM > MAX_REGS) begin : g_bad_reg_num
        $error("apb_register_if supports between 2 and 8 registers");
    end

    // addresses wrap onto the register file.
    assign reg_idx      = apb_addr[REG_ADDR_W-1:0];
    assign setup_phase  = (state == IDLE) && apb_psel && !apb_enab;
    assign write_commit = (state == ACCESS) && apb_psel && apb_enab && apb_rw;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= setup_phase ? ACCESS : IDLE;
                ACCESS:  state <= IDLE;   // no wait states.
                default: state <= IDLE;
            endcase
        end
    end

    // ack is high for exactly the access cycle.
    assign apb_ack = (state == ACCESS);

    always_ff @(posedge clk) begin
        if (setup_phase && !apb_rw) begin
            apb_datao <= regs[reg_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < MAX_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_commit) begin
            regs[reg_idx] <= apb_datai;
        end
    end

    assign R0 = regs[0];
    assign R1 = regs[1];
    assign R2 = regs[2];
    assign R3 = regs[3];
    assign R4 = regs[4];
    assign R5 = regs[5];
    assign R6 = regs[6];
    assign R7 = regs[7];

    a_enab_needs_psel: assert property (@(posedge clk) disable iff (!resetn)
        apb_enab |-> apb_psel)
        else $error("apb_enab high without apb_psel");

    a_ack_single: assert property (@(posedge clk) disable iff (!resetn)
        apb_ack |=> !apb_ack)
        else $error("apb_ack high for two cycles in a row");

    // the master must hold enab through the whole access cycle.
    a_ack_in_access: assert property (@(posedge clk) disable iff (!resetn)
        apb_ack |-> apb_enab)
        else $error("apb_ack high outside the access cycle");

endmodule

`default_nettype wire

//--- src/pwm_channel.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_channel
    import pwm_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire logic       enable,
    input  wire logic       tick,
    input  wire pwm_count_t period,
    input  wire pwm_count_t duty,
    output logic            pwm_out
);

    pwm_count_t cnt;
    pwm_count_t period_sh;
    pwm_count_t duty_sh;
    logic       wrap;

    assign wrap = tick && (cnt == period_sh);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt       <= '0;
            period_sh <= '0;
            duty_sh   <= '0;
        end else if (!enable) begin
            cnt       <= '0;
            period_sh <= period;  // track the registers while stopped.
            duty_sh   <= duty;
        end else if (wrap) begin
            cnt       <= '0;
            period_sh <= period;
            duty_sh   <= duty;
        end else if (tick) begin
            cnt <= cnt + 1'b1;
        end
    end

    // the compare uses the current shadow pair, so an update never splits a period.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pwm_out <= 1'b0;
        end else begin
            pwm_out <= enable && (cnt < duty_sh);
        end
    end

    a_off_when_disabled: assert property (@(posedge clk) disable iff (!resetn)
        !enable |=> !pwm_out)
        else $error("pwm_out high after channel disable");

    // a shorter period written mid-cycle must not strand the counter above it.
    a_cnt_in_range: assert property (@(posedge clk) disable iff (!resetn)
        cnt <= period_sh)
        else $error("channel count above shadow period");

endmodule

`default_nettype wire

//--- src/pwm_config.svh
`ifndef PWM_CONFIG_SVH
`define PWM_CONFIG_SVH

// APB data and address widths.
`define DATA_APB 32
`define ADDR_APB 8

// number of registers in the APB register file.
`define REG_NUM 8

// width of a channel counter and of its period and duty.
`define PWM_CNT_W 16

// width of the prescaler divisor field in the control register.
`define PRESC_W 8

`endif

//--- src/pwm_pkg.sv
`default_nettype none

`include "pwm_config.svh"

package pwm_pkg;

    typedef logic [`DATA_APB-1:0]  apb_word_t;
    typedef logic [`ADDR_APB-1:0]  apb_addr_t;
    typedef logic [`PWM_CNT_W-1:0] pwm_count_t;
    typedef logic [`PRESC_W-1:0]   presc_div_t;

    // register map, indexed by the low address bits.
    typedef enum logic [2:0] {
        REG_CTRL       = 3'd0,  // enables in bits 1:0, divisor in bits 15:8.
        REG_CH0_PERIOD = 3'd1,
        REG_CH0_DUTY   = 3'd2,
        REG_CH1_PERIOD = 3'd3,
        REG_CH1_DUTY   = 3'd4,
        REG_SCRATCH0   = 3'd5,
        REG_SCRATCH1   = 3'd6,
        REG_SCRATCH2   = 3'd7
    } reg_index_e;

endpackage

`default_nettype wire

//--- src/pwm_prescaler.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_prescaler
    import pwm_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire logic       run,
    input  wire presc_div_t divisor,
    output logic            tick
);

    presc_div_t cnt;

    // tick fires once every divisor+1 clocks while running.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (!run) begin
            cnt  <= divisor;  // restart a full interval when run comes back.
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= divisor;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    a_no_tick_when_idle: assert property (@(posedge clk) disable iff (!resetn)
        !run |=> !tick)
        else $error("prescaler tick while stopped");

endmodule

`default_nettype wire

//--- src/pwm_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwm_config.svh"

module pwm_subsystem_top
    import pwm_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      resetn,

    input  wire logic      apb_psel,
    input  wire logic      apb_enab,
    input  wire logic      apb_rw,
    input  wire apb_addr_t apb_addr,
    input  wire apb_word_t apb_datai,
    output apb_word_t      apb_datao,
    output logic           apb_ack,

    output logic [1:0]     pwm_out
);

    // only the registers below the scratch area drive the PWM.
    localparam int CFG_REGS     = int'(REG_SCRATCH0);
    localparam int CTRL_DIV_LSB = 8;

    apb_word_t  cfg_reg [CFG_REGS];
    logic [1:0] ch_enable;
    presc_div_t presc_div;
    logic       presc_run;
    logic       tick;

    assign ch_enable = cfg_reg[REG_CTRL][1:0];
    assign presc_div = cfg_reg[REG_CTRL][CTRL_DIV_LSB +: `PRESC_W];
    assign presc_run = |ch_enable;  // one shared tick for both channels.

    apb_register_if #(
        .REG_NUM (`REG_NUM)
    ) apb_register_if_i (
        .clk       (clk),
        .resetn    (resetn),
        .apb_psel  (apb_psel),
        .apb_enab  (apb_enab),
        .apb_rw    (apb_rw),
        .apb_addr  (apb_addr),
        .apb_datai (apb_datai),
        .apb_datao (apb_datao),
        .apb_ack   (apb_ack),
        .R0        (cfg_reg[REG_CTRL]),
        .R1        (cfg_reg[REG_CH0_PERIOD]),
        .R2        (cfg_reg[REG_CH0_DUTY]),
        .R3        (cfg_reg[REG_CH1_PERIOD]),
        .R4        (cfg_reg[REG_CH1_DUTY]),
        .R5        (),
        .R6        (),
        .R7        ()
    );

    pwm_prescaler pwm_prescaler_i (
        .clk     (clk),
        .resetn  (resetn),
        .run     (presc_run),
        .divisor (presc_div),
        .tick    (tick)
    );

    pwm_channel ch0_i (
        .clk     (clk),
        .resetn  (resetn),
        .enable  (ch_enable[0]),
        .tick    (tick),
        .period  (cfg_reg[REG_CH0_PERIOD][`PWM_CNT_W-1:0]),
        .duty    (cfg_reg[REG_CH0_DUTY][`PWM_CNT_W-1:0]),
        .pwm_out (pwm_out[0])
    );

    pwm_channel ch1_i (
        .clk     (clk),
        .resetn  (resetn),
        .enable  (ch_enable[1]),
        .tick    (tick),
        .period  (cfg_reg[REG_CH1_PERIOD][`PWM_CNT_W-1:0]),
        .duty    (cfg_reg[REG_CH1_DUTY][`PWM_CNT_W-1:0]),
        .pwm_out (pwm_out[1])
    );

endmodule

`default_nettype wire
